// File: verilog.f
verilog/cart_pkg.sv
verilog/cart_config_regs.sv
verilog/simple_mapper.sv
verilog/mmc3_mapper.sv
verilog/scanline_irq.sv
verilog/cart_bus_mux.sv
verilog/cool_girl_top.sv
testbench/cool_girl_asserts.sv
testbench/tb_cool_girl.sv

// File: testbench/tb_cool_girl.sv
`timescale 1ns/1ps

module tb_cool_girl;

	localparam int BUDGET_CYCLES = 20 + 40 + 60 + 160 + 120 + 40; // Per-test cycle budgets
	localparam int TIMEOUT_NS    = BUDGET_CYCLES * 3 / 2 * 10;

	logic        m2;
	logic        ppu_addr_in;   // Reset
	logic        romsel;
	logic        cpu_rw_in;
	logic [14:0] cpu_addr_in;
	logic [7:0]  cpu_data_in;
	logic [13:0] cpu_addr_out;
	logic        flash_we;
	logic        flash_oe;
	logic        sram_ce;
	logic        sram_we;
	logic        sram_oe;
	logic        ppu_rd_in;
	logic        ppu_wr_in;
	logic [13:0] ppu_addr;
	logic [7:0]  ppu_addr_out;
	logic        ppu_rd_out;
	logic        ppu_wr_out;
	logic        ppu_ciram_a10;
	tri1         irq;           // Open drain with pull-up as on the CPU side

	int          errors;
	string       test_name;
	logic [7:0]  mmc3_r [0:7];  // Reference copy of r0-r7

	cool_girl_top dut (.*);

	always #5 m2 = ~m2;

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog: run did not finish within %0d ns, stopping", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			errors++;
			$display("Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	// Flash A26:A13 taken from the full byte address of a mapped 8 KB bank
	function automatic logic [13:0] rom_addr(input logic [12:0] base, input logic [4:0] mask,
		input logic [5:0] prg);
		logic [26:0] flash;
		flash = {base, 14'h0000} | ({8'h00, prg, 13'h0000} & ~{8'h00, mask, 14'h0000});
		return flash[26:13];
	endfunction

	function automatic logic [5:0] mmc3_prg(input int w, input int pm);
		case (w)
			0:       return pm ? cart_pkg::PRG_SECOND_LAST : mmc3_r[6][5:0];
			1:       return mmc3_r[7][5:0];
			2:       return pm ? mmc3_r[6][5:0] : cart_pkg::PRG_SECOND_LAST;
			default: return cart_pkg::PRG_LAST;
		endcase
	endfunction

	// 1 KB slot s of the pattern tables
	function automatic logic [7:0] mmc3_chr(input int s, input int cm);
		if ((s >> 2) == cm)
			return {mmc3_r[(s >> 1) & 1][7:1], s[0]}; // 2 KB half
		return mmc3_r[2 + (s & 3)];
	endfunction

	task automatic apply_reset;
		@(posedge m2);
		ppu_addr_in <= 1'b1;
		repeat (2) @(posedge m2);
		ppu_addr_in <= 1'b0;
		#2;
	endtask

	task automatic drive_cpu(input logic rs, input logic rw, input logic [14:0] a,
		input logic [7:0] d);
		@(posedge m2);
		romsel      <= rs;
		cpu_rw_in   <= rw;
		cpu_addr_in <= a;
		cpu_data_in <= d;
		#2; // Outputs settled while m2 is high
	endtask

	task automatic cpu_write(input logic rs, input logic [14:0] a, input logic [7:0] d);
		drive_cpu(rs, 1'b0, a, d);
		drive_cpu(1'b1, 1'b1, 15'h0000, 8'h00); // Write taken at this edge
	endtask

	task automatic cfg_write(input logic [2:0] off, input logic [7:0] d);
		cpu_write(1'b1, {3'b101, 9'h000, off}, d); // $5000 page
	endtask

	task automatic rom_read(input logic [14:0] a);
		drive_cpu(1'b0, 1'b1, a, 8'h00);
	endtask

	task automatic drive_ppu(input logic [13:0] a, input logic wr_n);
		@(posedge m2);
		ppu_addr  <= a;
		ppu_rd_in <= 1'b1;
		ppu_wr_in <= wr_n;
		#2;
	endtask

	task automatic ppu_read(input logic [13:0] a);
		@(posedge m2);
		ppu_addr  <= a;
		ppu_rd_in <= 1'b0;
		ppu_wr_in <= 1'b1;
		#2;
	endtask

	// A12 low for low samples then high for one
	task automatic a12_pulse(input int low);
		repeat (low - 1) @(posedge m2);
		drive_ppu(14'h1000, 1'b1);
		drive_ppu(14'h0000, 1'b1);
	endtask

	task automatic test_reset_state;
		test_name = "test_reset_state";
		apply_reset();
		rom_read(15'h0000);
		check_value("irq", 1, irq);
		check_value("flash_we", 1, flash_we);
		check_value("flash_oe", 0, flash_oe);
		check_value("sram_ce", 1, sram_ce);
		check_value("sram_we", 1, sram_we);
		check_value("sram_oe", 0, sram_oe);
		check_value("ppu_wr_out", 1, ppu_wr_out);
		check_value("ppu_rd_out", 1, ppu_rd_out);
		check_value("rom $8000", rom_addr(13'h0, 5'h0, 6'h0), cpu_addr_out);
	endtask

	task automatic test_config_page;
		logic [12:0] base;
		logic [4:0]  mask;
		logic [1:0]  page;
		logic [5:0]  bank;
		test_name = "test_config_page";
		apply_reset();
		base = $urandom;
		mask = $urandom;
		page = $urandom;
		bank = $urandom;
		cfg_write(3'd0, {3'b000, base[12:8]});
		cfg_write(3'd1, base[7:0]);
		cfg_write(3'd2, {3'b000, mask});
		cfg_write(3'd5, {bank, page}); // PRG preset above the page bits
		cfg_write(3'd7, 8'h07);        // SRAM, PRG and CHR writes on
		rom_read(15'h0000);
		check_value("rom $8000", rom_addr(base, mask, {bank[4:0], 1'b0}), cpu_addr_out);
		rom_read(15'h6000);
		check_value("rom $E000", rom_addr(base, mask, 6'h3F), cpu_addr_out);
		drive_cpu(1'b1, 1'b1, 15'h6000, 8'h00); // $6000 read
		check_value("sram page", {12'h000, page}, cpu_addr_out);
		check_value("sram_ce", 0, sram_ce);
		cfg_write(3'd7, 8'h87); // Lockout
		cfg_write(3'd1, ~base[7:0]);
		cfg_write(3'd2, ~{3'b000, mask});
		rom_read(15'h0000);
		check_value("locked rom", rom_addr(base, mask, {bank[4:0], 1'b0}), cpu_addr_out);
	endtask

	task automatic test_simple_mappers;
		logic [7:0]  d;
		logic [13:0] pa;
		int          i;
		test_name = "test_simple_mappers";
		apply_reset();
		cfg_write(3'd6, {3'b000, cart_pkg::MAPPER_UXROM});
		for (i = 0; i < 3; i++)
		begin
			d = $urandom;
			cpu_write(1'b0, 15'h0000, d);
			rom_read(15'h2000); // Upper half of the switched 16 KB
			check_value("uxrom $A000", rom_addr(13'h0, 5'h0, {d[4:0], 1'b1}), cpu_addr_out);
			rom_read(15'h4000);
			check_value("uxrom $C000", rom_addr(13'h0, 5'h0, 6'h3E), cpu_addr_out);
		end
		cfg_write(3'd6, {3'b000, cart_pkg::MAPPER_CNROM});
		d = $urandom;
		pa = $urandom;
		pa[13] = 1'b0; // Pattern tables only
		cpu_write(1'b0, 15'h0000, d);
		drive_ppu(pa, 1'b1);
		check_value("cnrom chr", {d[4:0], pa[12:10]}, ppu_addr_out);
		cfg_write(3'd6, {3'b000, cart_pkg::MAPPER_AXROM});
		d = $urandom;
		cpu_write(1'b0, 15'h0000, d);
		rom_read(15'h6000);
		check_value("axrom $E000", rom_addr(13'h0, 5'h0, {d[3:0], 2'b11}), cpu_addr_out);
		check_value("axrom a10", d[4], ppu_ciram_a10);
	endtask

	task automatic test_mmc3_banks;
		int i;
		int pm;
		int cm;
		int w;
		int s;
		test_name = "test_mmc3_banks";
		apply_reset();
		cfg_write(3'd6, {3'b000, cart_pkg::MAPPER_MMC3});
		for (i = 0; i < 8; i++)
		begin
			mmc3_r[i] = $urandom;
			cpu_write(1'b0, 15'h0000, i[7:0]);  // Bank select
			cpu_write(1'b0, 15'h0001, mmc3_r[i]);
		end
		for (pm = 0; pm < 2; pm++)
			for (cm = 0; cm < 2; cm++)
			begin
				cpu_write(1'b0, 15'h0000, {cm[0], pm[0], 6'd0});
				for (w = 0; w < 4; w++)
				begin
					rom_read({w[1:0], 13'h0000});
					check_value("mmc3 prg", rom_addr(13'h0, 5'h0, mmc3_prg(w, pm)), cpu_addr_out);
				end
				for (s = 0; s < 8; s++)
				begin
					drive_ppu({1'b0, s[2:0], 10'h000}, 1'b1);
					check_value("mmc3 chr", mmc3_chr(s, cm), ppu_addr_out);
				end
			end
		cpu_write(1'b0, 15'h2000, 8'h01); // Horizontal
		drive_ppu(14'h2400, 1'b1);
		check_value("horizontal $2400", 0, ppu_ciram_a10);
		drive_ppu(14'h2800, 1'b1);
		check_value("horizontal $2800", 1, ppu_ciram_a10);
		cpu_write(1'b0, 15'h2000, 8'h00); // Vertical
		check_value("vertical $2800", 0, ppu_ciram_a10);
		drive_ppu(14'h2400, 1'b1);
		check_value("vertical $2400", 1, ppu_ciram_a10);
	endtask

	task automatic test_scanline_irq;
		int n;
		int p;
		test_name = "test_scanline_irq";
		apply_reset();
		drive_ppu(14'h0000, 1'b1);
		cfg_write(3'd6, {3'b000, cart_pkg::MAPPER_MMC3});
		n = 1 + $urandom % 4;
		cpu_write(1'b0, 15'h4000, n[7:0]); // Latch
		cpu_write(1'b0, 15'h4001, 8'h00);  // Reload
		cpu_write(1'b0, 15'h6001, 8'h00);  // Enable
		for (p = 1; p <= n + 1; p++)
		begin
			a12_pulse(3 + $urandom % 3);
			check_value("irq after pulse", (p == n + 1) ? 0 : 1, irq);
			a12_pulse(2); // Too short to count
			check_value("irq after short pulse", (p == n + 1) ? 0 : 1, irq);
		end
		cpu_write(1'b0, 15'h6000, 8'h00); // Disable and ack
		check_value("irq after disable", 1, irq);
	endtask

	task automatic test_write_strobes;
		test_name = "test_write_strobes";
		apply_reset();
		cfg_write(3'd7, 8'h06); // PRG and CHR writes on
		drive_cpu(1'b0, 1'b0, 15'h1234, 8'h5A);
		check_value("flash_we on", 0, flash_we);
		check_value("flash_oe on write", 1, flash_oe);
		check_value("sram_we on write", 0, sram_we);
		check_value("sram_oe on write", 1, sram_oe);
		drive_ppu(14'h0400, 1'b0);
		check_value("ppu_wr_out on", 0, ppu_wr_out);
		drive_ppu(14'h2400, 1'b0);
		check_value("ppu_wr_out nametable", 1, ppu_wr_out);
		ppu_read(14'h0400);
		check_value("ppu_rd_out chr", 0, ppu_rd_out);
		ppu_read(14'h2400);
		check_value("ppu_rd_out nametable", 1, ppu_rd_out);
		cfg_write(3'd7, 8'h00);
		drive_cpu(1'b0, 1'b0, 15'h1234, 8'h5A);
		check_value("flash_we off", 1, flash_we);
		drive_ppu(14'h0400, 1'b0);
		check_value("ppu_wr_out off", 1, ppu_wr_out);
		drive_ppu(14'h0000, 1'b1);
		check_value("ppu_rd_out idle", 1, ppu_rd_out);
		drive_cpu(1'b1, 1'b1, 15'h0000, 8'h00);
	endtask

	initial
	begin
		void'($urandom(32'hb6c8_b0c3));
		errors      = 0;
		m2          = 1'b0;
		ppu_addr_in = 1'b1;
		romsel      = 1'b1;
		cpu_rw_in   = 1'b1;
		cpu_addr_in = 15'h0000;
		cpu_data_in = 8'h00;
		ppu_rd_in   = 1'b1;
		ppu_wr_in   = 1'b1;
		ppu_addr    = 14'h0000;
		test_reset_state();
		test_config_page();
		test_simple_mappers();
		test_mmc3_banks();
		test_scanline_irq();
		test_write_strobes();
		$display("Run complete: %0d check errors, %0d assertion failures", errors,
			dut.u_asserts.fail_count);
		if (errors == 0 && dut.u_asserts.fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: testbench/cool_girl_asserts.sv
`timescale 1ns/1ps

module cool_girl_asserts
(
	input logic m2,
	input logic ppu_addr_in,   // Reset
	input logic romsel,
	input logic cpu_rw_in,
	input logic flash_we,
	input logic sram_ce,
	input wire  irq
);

	int fail_count = 0;

	// SRAM only on the $6000 side
	// Sampled on the fall so m2 is still high
	a_sram_rom: assert property (@(negedge m2) disable iff (ppu_addr_in)
		!romsel |-> sram_ce)
	else
	begin
		fail_count++;
		$error("sram_ce low while romsel low");
	end

	// Flash write strobe only in CPU write cycles
	a_flash_we_read: assert property (@(posedge m2) disable iff (ppu_addr_in)
		cpu_rw_in |-> flash_we)
	else
	begin
		fail_count++;
		$error("flash_we low during a CPU read");
	end

	// Line free right after reset drops
	a_irq_reset: assert property (@(posedge m2) $fell(ppu_addr_in) |-> irq !== 1'b0)
	else
	begin
		fail_count++;
		$error("irq still pulled low after reset");
	end

endmodule

bind cool_girl_top cool_girl_asserts u_asserts (.m2(m2), .ppu_addr_in(ppu_addr_in),
	.romsel(romsel), .cpu_rw_in(cpu_rw_in), .flash_we(flash_we),
	.sram_ce(sram_ce), .irq(irq));

// File: verilog/cool_girl_top.sv
`timescale 1ns/1ps

module cool_girl_top
(
	input  logic        m2,
	input  logic        ppu_addr_in,   // Reset
	input  logic        romsel,
	input  logic        cpu_rw_in,
	input  logic [14:0] cpu_addr_in,
	input  logic [7:0]  cpu_data_in,
	output logic [13:0] cpu_addr_out,  // Flash A26:A13
	output logic        flash_we,
	output logic        flash_oe,
	output logic        sram_ce,
	output logic        sram_we,
	output logic        sram_oe,
	input  logic        ppu_rd_in,
	input  logic        ppu_wr_in,
	input  logic [13:0] ppu_addr,
	output logic [7:0]  ppu_addr_out,  // CHR A17:A10
	output logic        ppu_rd_out,
	output logic        ppu_wr_out,
	output logic        ppu_ciram_a10,
	output wire         irq
);

	cart_pkg::cpu_bus_t     bus;
	cart_pkg::cart_cfg_t    cfg;
	cart_pkg::bank_preset_t preset;
	cart_pkg::mirror_wr_t   mirror_simple;
	cart_pkg::mirror_wr_t   mirror_mmc3;
	cart_pkg::irq_ctl_t     irq_ctl;
	cart_pkg::prg_bank_t    simple_prg;
	cart_pkg::prg_bank_t    mmc3_prg;
	cart_pkg::chr_bank_t    simple_chr;
	cart_pkg::chr_bank_t    mmc3_chr;
	logic [1:0]             mirroring;
	logic                   irq_flag;

	assign bus = {romsel, cpu_rw_in, cpu_addr_in, cpu_data_in}; // CPU pins as one bus

	cart_config_regs u_cfg (.m2(m2), .ppu_addr_in(ppu_addr_in), .bus(bus),
		.mirror_simple(mirror_simple), .mirror_mmc3(mirror_mmc3), .cfg(cfg),
		.mirroring(mirroring), .preset(preset));

	simple_mapper u_simple (.m2(m2), .ppu_addr_in(ppu_addr_in), .bus(bus),
		.mapper(cfg.mapper), .preset(preset), .ppu_addr(ppu_addr), .prg(simple_prg),
		.chr(simple_chr), .mirror_wr(mirror_simple));

	mmc3_mapper u_mmc3 (.m2(m2), .ppu_addr_in(ppu_addr_in), .bus(bus),
		.mapper(cfg.mapper), .ppu_addr(ppu_addr), .prg(mmc3_prg), .chr(mmc3_chr),
		.mirror_wr(mirror_mmc3), .irq_ctl(irq_ctl));

	scanline_irq u_irq (.m2(m2), .ppu_addr_in(ppu_addr_in), .a12(ppu_addr[12]),
		.ctl(irq_ctl), .irq_flag(irq_flag));

	cart_bus_mux u_mux (.m2(m2), .bus(bus), .cfg(cfg), .mirroring(mirroring),
		.simple_prg(simple_prg), .mmc3_prg(mmc3_prg), .simple_chr(simple_chr),
		.mmc3_chr(mmc3_chr), .ppu_addr(ppu_addr), .ppu_rd_in(ppu_rd_in),
		.ppu_wr_in(ppu_wr_in), .irq_flag(irq_flag), .cpu_addr_out(cpu_addr_out),
		.flash_we(flash_we), .flash_oe(flash_oe), .sram_ce(sram_ce), .sram_we(sram_we),
		.sram_oe(sram_oe), .ppu_addr_out(ppu_addr_out), .ppu_rd_out(ppu_rd_out),
		.ppu_wr_out(ppu_wr_out), .ppu_ciram_a10(ppu_ciram_a10), .irq(irq));

endmodule

// File: verilog/cart_bus_mux.sv
`timescale 1ns/1ps

module cart_bus_mux
(
	input  logic                m2,
	input  cart_pkg::cpu_bus_t  bus,
	input  cart_pkg::cart_cfg_t cfg,
	input  logic [1:0]          mirroring,
	input  cart_pkg::prg_bank_t simple_prg,
	input  cart_pkg::prg_bank_t mmc3_prg,
	input  cart_pkg::chr_bank_t simple_chr,
	input  cart_pkg::chr_bank_t mmc3_chr,
	input  logic [13:0]         ppu_addr,
	input  logic                ppu_rd_in,
	input  logic                ppu_wr_in,
	input  logic                irq_flag,
	output logic [13:0]         cpu_addr_out, // Flash A26:A13
	output logic                flash_we,
	output logic                flash_oe,
	output logic                sram_ce,
	output logic                sram_we,
	output logic                sram_oe,
	output logic [7:0]          ppu_addr_out, // CHR A17:A10
	output logic                ppu_rd_out,
	output logic                ppu_wr_out,
	output logic                ppu_ciram_a10,
	output wire                 irq
);

	cart_pkg::prg_bank_t prg;
	cart_pkg::chr_bank_t chr;

	// Mapper bit 4 picks the MMC3 group
	assign prg = cfg.mapper[4] ? mmc3_prg : simple_prg;
	assign chr = cfg.mapper[4] ? mmc3_chr : simple_chr;

	// ROM gets base plus masked bank, $6000 side gets the SRAM page
	assign cpu_addr_out = ~bus.romsel ?
		{cfg.cpu_base | {8'h00, prg[5:1] & ~cfg.cpu_mask}, prg[0]} :
		{12'h000, cfg.sram_page};

	assign ppu_addr_out = {chr[7:3] & ~cfg.chr_mask, chr[2:0]};

	assign flash_we = bus.rw | bus.romsel | ~cfg.prg_write_enabled;
	assign flash_oe = ~bus.rw | bus.romsel;
	assign sram_ce  = ~(bus.addr[14] & bus.addr[13] & m2 & bus.romsel & cfg.sram_enabled);
	assign sram_we  = bus.rw;
	assign sram_oe  = ~bus.rw;

	// CHR chip only below $2000, CIRAM takes the rest
	assign ppu_rd_out = ppu_rd_in | ppu_addr[13];
	assign ppu_wr_out = ppu_wr_in | ppu_addr[13] | ~cfg.chr_write_enabled;

	always_comb
	begin
		case (mirroring)
			cart_pkg::MIRROR_VERTICAL:   ppu_ciram_a10 = ppu_addr[10];
			cart_pkg::MIRROR_HORIZONTAL: ppu_ciram_a10 = ppu_addr[11];
			cart_pkg::MIRROR_ONE_A:      ppu_ciram_a10 = 1'b0;
			default:                     ppu_ciram_a10 = 1'b1; // One-screen B
		endcase
	end

	assign irq = irq_flag ? 1'b0 : 1'bz; // Open drain to the CPU

endmodule

// File: verilog/scanline_irq.sv
`timescale 1ns/1ps

module scanline_irq
(
	input  logic               m2,
	input  logic               ppu_addr_in, // Reset
	input  logic               a12,
	input  cart_pkg::irq_ctl_t ctl,
	output logic               irq_flag
);

	logic [cart_pkg::A12_CNT_W-1:0] low_cnt;  // Saturating low-time count
	logic                           a12_prev;
	logic [7:0]                     latch;
	logic [7:0]                     counter;
	logic [7:0]                     counter_next;
	logic                           reload_pend;
	logic                           enabled;
	logic                           a12_rise;

	// Rise only counts after a long enough low stretch
	assign a12_rise = a12 & ~a12_prev & (low_cnt == cart_pkg::A12_LOW_CYCLES);

	// Reload on request or when the count ran out
	assign counter_next = (reload_pend || counter == 8'd0) ? latch : counter - 8'd1;

	// A12 low-time filter
	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			low_cnt  <= '0;
			a12_prev <= 1'b0;
		end
		else
		begin
			a12_prev <= a12;
			if (a12)
				low_cnt <= '0;
			else if (low_cnt != cart_pkg::A12_LOW_CYCLES)
				low_cnt <= low_cnt + 1'b1;
		end
	end

	// Counter, latch and flag
	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			latch       <= 8'h00;
			counter     <= 8'h00;
			reload_pend <= 1'b0;
			enabled     <= 1'b0;
			irq_flag    <= 1'b0;
		end
		else
		begin
			if (a12_rise)
			begin
				counter     <= counter_next;
				reload_pend <= 1'b0;
				if (counter_next == 8'd0 && enabled)
					irq_flag <= 1'b1;
			end
			// CPU writes land after the rise so they win
			if (ctl.latch_wr)
				latch <= ctl.data;
			if (ctl.reload_wr)
				reload_pend <= 1'b1;
			if (ctl.enable_wr)
				enabled <= 1'b1; // Leaves a pending IRQ in place
			if (ctl.disable_wr)
			begin
				enabled  <= 1'b0;
				irq_flag <= 1'b0; // Ack
			end
		end
	end

endmodule

// File: verilog/mmc3_mapper.sv
`timescale 1ns/1ps

module mmc3_mapper
(
	input  logic                 m2,
	input  logic                 ppu_addr_in,  // Reset
	input  cart_pkg::cpu_bus_t   bus,
	input  logic [4:0]           mapper,
	input  logic [13:0]          ppu_addr,
	output cart_pkg::prg_bank_t  prg,
	output cart_pkg::chr_bank_t  chr,
	output cart_pkg::mirror_wr_t mirror_wr,
	output cart_pkg::irq_ctl_t   irq_ctl
);

	logic [7:0] bank_r [0:7]; // r0-r1 2 KB CHR, r2-r5 1 KB CHR, r6-r7 PRG
	logic [2:0] bank_sel;
	logic       prg_mode;
	logic       chr_mode;
	logic       wr;
	logic [2:0] reg_sel;

	assign wr      = ~bus.rw & ~bus.romsel & (mapper == cart_pkg::MAPPER_MMC3);
	assign reg_sel = {bus.addr[14:13], bus.addr[0]}; // Register pair and even/odd

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			bank_sel <= 3'd0;
			prg_mode <= 1'b0;
			chr_mode <= 1'b0;
			bank_r   <= '{default: 8'h00};
		end
		else if (wr)
		begin
			case (reg_sel)
				3'b000: // $8000 even
				begin
					chr_mode <= bus.data[7];
					prg_mode <= bus.data[6];
					bank_sel <= bus.data[2:0];
				end
				3'b001: // $8001 odd
					bank_r[bank_sel] <= bus.data;
				default:
					bank_sel <= bank_sel; // Others are strobes only
			endcase
		end
	end

	// $A000 even, H/V mirroring
	assign mirror_wr.valid = wr & (reg_sel == 3'b010);
	assign mirror_wr.mode  = {1'b0, bus.data[0]};

	// $C000/$C001 and $E000/$E001 go to the scanline counter
	assign irq_ctl.latch_wr   = wr & (reg_sel == 3'b100);
	assign irq_ctl.reload_wr  = wr & (reg_sel == 3'b101);
	assign irq_ctl.disable_wr = wr & (reg_sel == 3'b110);
	assign irq_ctl.enable_wr  = wr & (reg_sel == 3'b111);
	assign irq_ctl.data       = bus.data;

	// PRG windows, 8 KB each
	always_comb
	begin
		case (bus.addr[14:13])
			2'b00:   prg = prg_mode ? cart_pkg::PRG_SECOND_LAST : bank_r[6][5:0];
			2'b01:   prg = bank_r[7][5:0];                                          // Always r7
			2'b10:   prg = prg_mode ? bank_r[6][5:0] : cart_pkg::PRG_SECOND_LAST;
			default: prg = cart_pkg::PRG_LAST;                                      // $E000 fixed
		endcase
	end

	// CHR mode picks which half gets the 2 KB banks
	always_comb
	begin
		if (ppu_addr[12] == chr_mode)
		begin
			if (ppu_addr[11])
				chr = {bank_r[1][7:1], ppu_addr[10]};
			else
				chr = {bank_r[0][7:1], ppu_addr[10]};
		end
		else
		begin
			case (ppu_addr[11:10])
				2'b00:   chr = bank_r[2];
				2'b01:   chr = bank_r[3];
				2'b10:   chr = bank_r[4];
				default: chr = bank_r[5];
			endcase
		end
	end

endmodule

// File: verilog/simple_mapper.sv
`timescale 1ns/1ps

module simple_mapper
(
	input  logic                   m2,
	input  logic                   ppu_addr_in,  // Reset
	input  cart_pkg::cpu_bus_t     bus,
	input  logic [4:0]             mapper,
	input  cart_pkg::bank_preset_t preset,
	input  logic [13:0]            ppu_addr,
	output cart_pkg::prg_bank_t    prg,
	output cart_pkg::chr_bank_t    chr,
	output cart_pkg::mirror_wr_t   mirror_wr
);

	logic [7:0] r0;      // CHR bank
	logic [7:0] r1;      // PRG bank
	logic       rom_wr;

	assign rom_wr = ~bus.rw & ~bus.romsel; // Any write to $8000-$FFFF

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			r0 <= 8'h00;
			r1 <= 8'h00;
		end
		else
		begin
			if (preset.chr_wr)
				r0 <= preset.data;
			if (preset.prg_wr)
				r1 <= preset.data;
			if (rom_wr)
			begin
				case (mapper)
					cart_pkg::MAPPER_UXROM: r1 <= bus.data;
					cart_pkg::MAPPER_CNROM: r0 <= bus.data;
					cart_pkg::MAPPER_AXROM: r1 <= {3'b000, bus.data[4:0]};
					default:                r0 <= r0; // NROM has no registers
				endcase
			end
		end
	end

	// AxROM one-screen select rides on data bit 4
	assign mirror_wr.valid = rom_wr & (mapper == cart_pkg::MAPPER_AXROM);
	assign mirror_wr.mode  = {1'b1, bus.data[4]};

	always_comb
	begin
		if (mapper[3])
			prg = {r1[3:0], bus.addr[14:13]};             // One 32 KB window
		else if (bus.addr[14])
			prg = {cart_pkg::PRG_LAST[5:1], bus.addr[13]}; // Last 16 KB at $C000
		else
			prg = {r1[4:0], bus.addr[13]};                 // Switchable $8000
	end

	assign chr = {r0[4:0], ppu_addr[12:10]}; // 8 KB CHR bank

endmodule

// File: verilog/cart_config_regs.sv
`timescale 1ns/1ps

module cart_config_regs
(
	input  logic                     m2,
	input  logic                     ppu_addr_in,   // Reset
	input  cart_pkg::cpu_bus_t       bus,
	input  cart_pkg::mirror_wr_t     mirror_simple,
	input  cart_pkg::mirror_wr_t     mirror_mmc3,
	output cart_pkg::cart_cfg_t      cfg,
	output logic [1:0]               mirroring,
	output cart_pkg::bank_preset_t   preset
);

	logic       lockout;
	logic       cfg_wr;
	logic [2:0] offset;

	assign offset = bus.addr[2:0];

	// Write to $5000-$5FFF while the page is still open
	assign cfg_wr = ~bus.rw & bus.romsel & (bus.addr[14:12] == cart_pkg::CFG_PAGE) & ~lockout;

	// Direct bank writes go out in the write cycle itself
	assign preset.chr_wr = cfg_wr & (offset == cart_pkg::CFG_CHR_PRESET);
	assign preset.prg_wr = cfg_wr & (offset == cart_pkg::CFG_SRAM_PAGE);
	assign preset.data   = (offset == cart_pkg::CFG_SRAM_PAGE) ?
		{2'b00, bus.data[7:2]} : bus.data; // PRG bank sits above SRAM page bits

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cfg     <= '0;
			lockout <= 1'b0;
		end
		else if (cfg_wr)
		begin
			case (offset)
				cart_pkg::CFG_BASE_HI:
					cfg.cpu_base[12:8] <= bus.data[4:0]; // A26:A22
				cart_pkg::CFG_BASE_LO:
					cfg.cpu_base[7:0] <= bus.data;       // A21:A14
				cart_pkg::CFG_PRG_MASK:
					cfg.cpu_mask <= bus.data[4:0];       // Mask for A18:A14
				cart_pkg::CFG_CHR_MASK:
					cfg.chr_mask <= bus.data[4:0];       // Mask for A17:A13
				cart_pkg::CFG_SRAM_PAGE:
					cfg.sram_page <= bus.data[1:0];
				cart_pkg::CFG_MAPPER:
				begin
					cfg.flags  <= bus.data[7:5];
					cfg.mapper <= bus.data[4:0];
				end
				cart_pkg::CFG_CONTROL:
				begin
					lockout               <= bus.data[7]; // Sticky until reset
					cfg.prg_write_enabled <= bus.data[2];
					cfg.chr_write_enabled <= bus.data[1];
					cfg.sram_enabled      <= bus.data[0];
				end
				default:
					lockout <= lockout; // CHR preset leaves config alone
			endcase
		end
	end

	// Shared mirroring, mapper pulses take priority
	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
			mirroring <= cart_pkg::MIRROR_VERTICAL;
		else if (mirror_simple.valid)
			mirroring <= mirror_simple.mode;
		else if (mirror_mmc3.valid)
			mirroring <= mirror_mmc3.mode;
		else if (cfg_wr && offset == cart_pkg::CFG_CONTROL)
			mirroring <= bus.data[4:3];
	end

endmodule

// File: verilog/cart_pkg.sv
package cart_pkg;

	// Mapper codes as written to $5xx6 bits 4:0
	localparam logic [4:0] MAPPER_NROM  = 5'd0;
	localparam logic [4:0] MAPPER_UXROM = 5'd1;
	localparam logic [4:0] MAPPER_CNROM = 5'd2;
	localparam logic [4:0] MAPPER_AXROM = 5'd8;  // Bit 3 set, 32 KB PRG layout
	localparam logic [4:0] MAPPER_MMC3  = 5'd20; // Bit 4 set, MMC3 group

	// CPU A14:A12 of the config page, $5000-$5FFF
	localparam logic [2:0] CFG_PAGE = 3'b101;

	// Config register offsets, CPU A2:A0
	localparam logic [2:0] CFG_BASE_HI    = 3'd0; // Base A26:A22
	localparam logic [2:0] CFG_BASE_LO    = 3'd1; // Base A21:A14
	localparam logic [2:0] CFG_PRG_MASK   = 3'd2;
	localparam logic [2:0] CFG_CHR_PRESET = 3'd3; // Direct r0 write
	localparam logic [2:0] CFG_CHR_MASK   = 3'd4;
	localparam logic [2:0] CFG_SRAM_PAGE  = 3'd5; // Also direct r1 write
	localparam logic [2:0] CFG_MAPPER     = 3'd6;
	localparam logic [2:0] CFG_CONTROL    = 3'd7; // Lockout, mirroring, enables

	// CIRAM A10 modes
	localparam logic [1:0] MIRROR_VERTICAL   = 2'd0;
	localparam logic [1:0] MIRROR_HORIZONTAL = 2'd1;
	localparam logic [1:0] MIRROR_ONE_A      = 2'd2;
	localparam logic [1:0] MIRROR_ONE_B      = 2'd3;

	// Scanline filter, m2 rises with A12 low before a rise counts
	localparam int A12_LOW_CYCLES = 3;
	localparam int A12_CNT_W      = $clog2(A12_LOW_CYCLES + 1);

	// Fixed MMC3 8 KB banks
	localparam logic [5:0] PRG_LAST        = 6'd63;
	localparam logic [5:0] PRG_SECOND_LAST = 6'd62;

	localparam int CPU_BASE_W = 13; // Flash A26:A14
	localparam int MASK_W     = 5;

	typedef logic [5:0] prg_bank_t; // Mapped CPU A18:A13
	typedef logic [7:0] chr_bank_t; // Mapped PPU A17:A10

	typedef struct packed {
		logic       romsel;
		logic       rw;
		logic [14:0] addr;
		logic [7:0] data;
	} cpu_bus_t;

	typedef struct packed {
		logic [CPU_BASE_W-1:0] cpu_base;
		logic [MASK_W-1:0]     cpu_mask;
		logic [MASK_W-1:0]     chr_mask;
		logic [1:0]            sram_page;
		logic [4:0]            mapper;
		logic [2:0]            flags;
		logic                  sram_enabled;
		logic                  prg_write_enabled;
		logic                  chr_write_enabled;
	} cart_cfg_t;

	typedef struct packed {
		logic       valid;
		logic [1:0] mode;
	} mirror_wr_t;

	typedef struct packed {
		logic       chr_wr;
		logic       prg_wr;
		logic [7:0] data;
	} bank_preset_t;

	typedef struct packed {
		logic       latch_wr;
		logic       reload_wr;
		logic       enable_wr;
		logic       disable_wr;
		logic [7:0] data;
	} irq_ctl_t;

endpackage
